//--- common/la_pkg.sv
package la_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // One-hot ALU operation, bit positions below
    typedef logic [11:0] alu_op_t;

    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        EXECUTE,
        MEMORY,
        WRITEBACK
    } core_state_t;

    // Same instruction word seen as four encodings
    typedef union packed {
        struct packed {
            logic [16:0] opcode;
            reg_idx_t    rk;
            reg_idx_t    rj;
            reg_idx_t    rd;
        } fmt_3r;
        struct packed {
            logic [9:0]  opcode;
            logic [11:0] si12;
            reg_idx_t    rj;
            reg_idx_t    rd;
        } fmt_2ri12;
        struct packed {
            logic [6:0]  opcode;
            logic [19:0] si20;
            reg_idx_t    rd;
        } fmt_1ri20;
        struct packed {
            logic [5:0]  opcode;
            logic [15:0] offs16;
            reg_idx_t    rj;
            reg_idx_t    rd;
        } fmt_2ri16;
    } inst_word_u;

endpackage

//--- common/ctrl_if.sv
`timescale 1ns/10ps

interface ctrl_if;
    la_pkg::alu_op_t  alu_op;
    logic             src1_is_pc;
    logic             src2_is_imm;
    la_pkg::word_t    imm;
    la_pkg::word_t    br_offs;
    logic             is_beq;
    logic             is_bne;
    logic             is_jump;      // b, bl and jirl
    logic             is_jirl;
    logic             mem_we;
    logic             res_from_mem;
    logic             gr_we;
    la_pkg::reg_idx_t dest;
    logic             rkd_sel;      // Second read port takes rd

    modport decoder (
        output alu_op, src1_is_pc, src2_is_imm, imm, br_offs,
        output is_beq, is_bne, is_jump, is_jirl,
        output mem_we, res_from_mem, gr_we, dest, rkd_sel
    );

    modport exec (
        input alu_op, src1_is_pc, src2_is_imm, imm, br_offs,
        input is_beq, is_bne, is_jump, is_jirl
    );

    modport result (
        input gr_we, dest, res_from_mem, mem_we
    );
endinterface

//--- execute/alu.sv
`timescale 1ns/10ps

module alu (
    input  la_pkg::alu_op_t alu_op,
    input  la_pkg::word_t   src1,
    input  la_pkg::word_t   src2,
    output la_pkg::word_t   result
);

    logic          use_sub;
    la_pkg::word_t adder_b;
    la_pkg::word_t sum;
    logic          carry_out;
    logic          slt_bit;
    logic          sltu_bit;
    logic [4:0]    shamt;
    la_pkg::word_t sra_result;

    // Subtract and both compares share one adder
    assign use_sub = alu_op[la_pkg::ALU_SUB] | alu_op[la_pkg::ALU_SLT]
                   | alu_op[la_pkg::ALU_SLTU];
    assign adder_b = use_sub ? ~src2 : src2;
    assign {carry_out, sum} = {1'b0, src1} + {1'b0, adder_b} + {32'd0, use_sub};

    assign slt_bit  = (src1[31] & ~src2[31])
                    | (~(src1[31] ^ src2[31]) & sum[31]);
    assign sltu_bit = ~carry_out;                   // No carry means borrow

    assign shamt = src2[4:0];

    assign sra_result = $signed(src1) >>> shamt;

    assign result =
          ({32{alu_op[la_pkg::ALU_ADD] | alu_op[la_pkg::ALU_SUB]}} & sum)
        | ({32{alu_op[la_pkg::ALU_SLT]}}  & {31'd0, slt_bit})
        | ({32{alu_op[la_pkg::ALU_SLTU]}} & {31'd0, sltu_bit})
        | ({32{alu_op[la_pkg::ALU_AND]}}  & (src1 & src2))
        | ({32{alu_op[la_pkg::ALU_NOR]}}  & ~(src1 | src2))
        | ({32{alu_op[la_pkg::ALU_OR]}}   & (src1 | src2))
        | ({32{alu_op[la_pkg::ALU_XOR]}}  & (src1 ^ src2))
        | ({32{alu_op[la_pkg::ALU_SLL]}}  & (src1 << shamt))
        | ({32{alu_op[la_pkg::ALU_SRL]}}  & (src1 >> shamt))
        | ({32{alu_op[la_pkg::ALU_SRA]}}  & sra_result)
        | ({32{alu_op[la_pkg::ALU_LUI]}}  & src2);   // Upper immediate already shifted

endmodule

//--- execute/exec_unit.sv
`timescale 1ns/10ps

module exec_unit (
    ctrl_if.exec          ctrl,
    input  la_pkg::word_t pc,
    input  la_pkg::word_t rj_value,
    input  la_pkg::word_t rkd_value,
    output la_pkg::word_t alu_result,
    output logic          br_taken,
    output la_pkg::word_t br_target
);

    la_pkg::word_t src1;
    la_pkg::word_t src2;
    logic          rj_eq_rd;

    assign src1 = ctrl.src1_is_pc  ? pc        : rj_value;
    assign src2 = ctrl.src2_is_imm ? ctrl.imm  : rkd_value;

    alu u_alu (
        .alu_op (ctrl.alu_op),
        .src1   (src1),
        .src2   (src2),
        .result (alu_result)
    );

    // Second read port holds rd for beq and bne
    assign rj_eq_rd = rj_value == rkd_value;

    assign br_taken = (ctrl.is_beq & rj_eq_rd)
                    | (ctrl.is_bne & ~rj_eq_rd)
                    | ctrl.is_jump;

    assign br_target = ctrl.is_jirl ? rj_value + ctrl.br_offs   // Register-relative jump
                                    : pc + ctrl.br_offs;

endmodule

//--- decode/inst_decoder.sv
`timescale 1ns/10ps

module inst_decoder (
    input  la_pkg::inst_word_u inst,
    ctrl_if.decoder            ctrl,
    output la_pkg::reg_idx_t   rf_raddr1,
    output la_pkg::reg_idx_t   rf_raddr2,
    output logic               has_mem,
    output logic               is_load,
    output logic               is_branch_only
);

    // Three-register and shift-immediate encodings, op[31:15]
    localparam logic [16:0] OP_ADD  = {6'h00, 4'h0, 2'h1, 5'h00};
    localparam logic [16:0] OP_SUB  = {6'h00, 4'h0, 2'h1, 5'h02};
    localparam logic [16:0] OP_SLT  = {6'h00, 4'h0, 2'h1, 5'h04};
    localparam logic [16:0] OP_SLTU = {6'h00, 4'h0, 2'h1, 5'h05};
    localparam logic [16:0] OP_NOR  = {6'h00, 4'h0, 2'h1, 5'h08};
    localparam logic [16:0] OP_AND  = {6'h00, 4'h0, 2'h1, 5'h09};
    localparam logic [16:0] OP_OR   = {6'h00, 4'h0, 2'h1, 5'h0a};
    localparam logic [16:0] OP_XOR  = {6'h00, 4'h0, 2'h1, 5'h0b};
    localparam logic [16:0] OP_SLLI = {6'h00, 4'h1, 2'h0, 5'h01};
    localparam logic [16:0] OP_SRLI = {6'h00, 4'h1, 2'h0, 5'h09};
    localparam logic [16:0] OP_SRAI = {6'h00, 4'h1, 2'h0, 5'h11};
    localparam logic [9:0]  OP_ADDI = {6'h00, 4'ha};
    localparam logic [9:0]  OP_LDW  = {6'h0a, 4'h2};
    localparam logic [9:0]  OP_STW  = {6'h0a, 4'h6};
    localparam logic [6:0]  OP_LU12I = 7'h0a;
    localparam logic [5:0]  OP_JIRL = 6'h13;
    localparam logic [5:0]  OP_B    = 6'h14;
    localparam logic [5:0]  OP_BL   = 6'h15;
    localparam logic [5:0]  OP_BEQ  = 6'h16;
    localparam logic [5:0]  OP_BNE  = 6'h17;

    logic inst_add, inst_sub, inst_slt, inst_sltu;
    logic inst_nor, inst_and, inst_or, inst_xor;
    logic inst_slli, inst_srli, inst_srai, inst_addi;
    logic inst_ld, inst_st, inst_lu12i;
    logic inst_jirl, inst_b, inst_bl, inst_beq, inst_bne;
    logic src2_is_4;
    logic [11:0] si12;
    logic [15:0] offs16;
    logic [25:0] offs26;

    assign inst_add   = inst.fmt_3r.opcode == OP_ADD;
    assign inst_sub   = inst.fmt_3r.opcode == OP_SUB;
    assign inst_slt   = inst.fmt_3r.opcode == OP_SLT;
    assign inst_sltu  = inst.fmt_3r.opcode == OP_SLTU;
    assign inst_nor   = inst.fmt_3r.opcode == OP_NOR;
    assign inst_and   = inst.fmt_3r.opcode == OP_AND;
    assign inst_or    = inst.fmt_3r.opcode == OP_OR;
    assign inst_xor   = inst.fmt_3r.opcode == OP_XOR;
    assign inst_slli  = inst.fmt_3r.opcode == OP_SLLI;
    assign inst_srli  = inst.fmt_3r.opcode == OP_SRLI;
    assign inst_srai  = inst.fmt_3r.opcode == OP_SRAI;
    assign inst_addi  = inst.fmt_2ri12.opcode == OP_ADDI;
    assign inst_ld    = inst.fmt_2ri12.opcode == OP_LDW;
    assign inst_st    = inst.fmt_2ri12.opcode == OP_STW;
    assign inst_lu12i = inst.fmt_1ri20.opcode == OP_LU12I;
    assign inst_jirl  = inst.fmt_2ri16.opcode == OP_JIRL;
    assign inst_b     = inst.fmt_2ri16.opcode == OP_B;
    assign inst_bl    = inst.fmt_2ri16.opcode == OP_BL;
    assign inst_beq   = inst.fmt_2ri16.opcode == OP_BEQ;
    assign inst_bne   = inst.fmt_2ri16.opcode == OP_BNE;

    assign ctrl.alu_op[la_pkg::ALU_ADD]  = inst_add | inst_addi | inst_ld | inst_st
                                         | inst_jirl | inst_bl;
    assign ctrl.alu_op[la_pkg::ALU_SUB]  = inst_sub;
    assign ctrl.alu_op[la_pkg::ALU_SLT]  = inst_slt;
    assign ctrl.alu_op[la_pkg::ALU_SLTU] = inst_sltu;
    assign ctrl.alu_op[la_pkg::ALU_AND]  = inst_and;
    assign ctrl.alu_op[la_pkg::ALU_NOR]  = inst_nor;
    assign ctrl.alu_op[la_pkg::ALU_OR]   = inst_or;
    assign ctrl.alu_op[la_pkg::ALU_XOR]  = inst_xor;
    assign ctrl.alu_op[la_pkg::ALU_SLL]  = inst_slli;
    assign ctrl.alu_op[la_pkg::ALU_SRL]  = inst_srli;
    assign ctrl.alu_op[la_pkg::ALU_SRA]  = inst_srai;
    assign ctrl.alu_op[la_pkg::ALU_LUI]  = inst_lu12i;

    assign si12   = inst.fmt_2ri12.si12;    // Low five bits double as ui5
    assign offs16 = inst.fmt_2ri16.offs16;
    assign offs26 = {inst.fmt_2ri16.rj, inst.fmt_2ri16.rd, inst.fmt_2ri16.offs16};

    assign src2_is_4 = inst_jirl | inst_bl;     // Link value is pc + 4

    assign ctrl.imm = src2_is_4  ? 32'd4 :
                      inst_lu12i ? {inst.fmt_1ri20.si20, 12'b0} :
                                   {{20{si12[11]}}, si12};

    assign ctrl.br_offs = (inst_b | inst_bl) ? {{4{offs26[25]}}, offs26, 2'b0}
                                             : {{14{offs16[15]}}, offs16, 2'b0};

    assign ctrl.src1_is_pc  = inst_jirl | inst_bl;
    assign ctrl.src2_is_imm = inst_slli | inst_srli | inst_srai | inst_addi | inst_ld
                            | inst_st | inst_lu12i | inst_jirl | inst_bl;

    assign ctrl.is_beq       = inst_beq;
    assign ctrl.is_bne       = inst_bne;
    assign ctrl.is_jump      = inst_b | inst_bl | inst_jirl;
    assign ctrl.is_jirl      = inst_jirl;
    assign ctrl.mem_we       = inst_st;
    assign ctrl.res_from_mem = inst_ld;
    assign ctrl.gr_we        = inst_add | inst_sub | inst_slt | inst_sltu | inst_nor
                             | inst_and | inst_or | inst_xor | inst_slli | inst_srli
                             | inst_srai | inst_addi | inst_ld | inst_lu12i
                             | inst_jirl | inst_bl;
    assign ctrl.dest         = inst_bl ? 5'd1 : inst.fmt_3r.rd;
    assign ctrl.rkd_sel      = inst_beq | inst_bne | inst_st;

    assign rf_raddr1 = inst.fmt_3r.rj;
    assign rf_raddr2 = ctrl.rkd_sel ? inst.fmt_3r.rd : inst.fmt_3r.rk;

    // Instruction class for the sequencer
    assign has_mem        = inst_ld | inst_st;
    assign is_load        = inst_ld;
    assign is_branch_only = inst_b | inst_beq | inst_bne;

endmodule

//--- rtl/regfile.sv
`timescale 1ns/10ps

module regfile (
    input  logic             clk,
    input  la_pkg::reg_idx_t raddr1,
    output la_pkg::word_t    rdata1,
    input  la_pkg::reg_idx_t raddr2,
    output la_pkg::word_t    rdata2,
    input  logic             we,
    input  la_pkg::reg_idx_t waddr,
    input  la_pkg::word_t    wdata
);

    la_pkg::word_t rf [32];

    always_ff @(posedge clk) begin
        if (we && waddr != 5'd0) begin
            rf[waddr] <= wdata;
        end
    end

    // r0 is hardwired to zero
    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : rf[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : rf[raddr2];

endmodule

//--- rtl/fetch_control.sv
`timescale 1ns/10ps

module fetch_control #(
    parameter la_pkg::word_t RESET_PC = 32'h1c00_0000
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                br_taken,
    input  la_pkg::word_t       br_target,
    input  la_pkg::word_t       inst_sram_rdata,
    output la_pkg::core_state_t state,
    output la_pkg::word_t       pc,
    output la_pkg::inst_word_u  inst,
    input  logic                has_mem,
    input  logic                is_load,
    input  logic                is_branch_only
);

    la_pkg::core_state_t next_state;
    la_pkg::inst_word_u  inst_q;

    always_comb begin
        next_state = la_pkg::FETCH;
        case (state)
            la_pkg::FETCH:     next_state = la_pkg::DECODE;
            la_pkg::DECODE:    next_state = is_branch_only ? la_pkg::FETCH : la_pkg::EXECUTE;
            la_pkg::EXECUTE:   next_state = has_mem ? la_pkg::MEMORY : la_pkg::WRITEBACK;
            la_pkg::MEMORY:    next_state = is_load ? la_pkg::WRITEBACK : la_pkg::FETCH;
            la_pkg::WRITEBACK: next_state = la_pkg::FETCH;
            default:           next_state = la_pkg::FETCH;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= la_pkg::FETCH;
            pc     <= RESET_PC;
            inst_q <= '0;                   // Decodes to no operation
        end else begin
            state <= next_state;
            if (state == la_pkg::DECODE) begin
                pc     <= br_taken ? br_target : pc + 32'd4;
                inst_q <= la_pkg::inst_word_u'(inst_sram_rdata);
            end
        end
    end

    // SRAM data is decoded directly while it is being captured
    assign inst = (state == la_pkg::DECODE) ? la_pkg::inst_word_u'(inst_sram_rdata)
                                            : inst_q;

endmodule

//--- rtl/result_unit.sv
`timescale 1ns/10ps

module result_unit (
    input  logic                clk,
    input  logic                reset,
    input  la_pkg::core_state_t state,
    ctrl_if.result              ctrl,
    input  la_pkg::word_t       alu_result,
    input  la_pkg::word_t       rkd_value,
    input  la_pkg::word_t       pc,
    input  la_pkg::word_t       data_sram_rdata,
    output logic                data_sram_we,
    output la_pkg::word_t       data_sram_addr,
    output la_pkg::word_t       data_sram_wdata,
    output logic                rf_we,
    output la_pkg::reg_idx_t    rf_waddr,
    output la_pkg::word_t       rf_wdata,
    output la_pkg::word_t       debug_wb_pc,
    output logic [3:0]          debug_wb_rf_we,
    output la_pkg::reg_idx_t    debug_wb_rf_wnum,
    output la_pkg::word_t       debug_wb_rf_wdata
);

    la_pkg::word_t result_q;
    la_pkg::word_t inst_pc;

    // Store strobe lasts exactly the MEMORY cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            data_sram_we <= 1'b0;
        end else begin
            data_sram_we <= (state == la_pkg::EXECUTE) && ctrl.mem_we;
        end
    end

    always_ff @(posedge clk) begin
        if (state == la_pkg::FETCH) begin
            inst_pc <= pc;                      // pc of the instruction in flight
        end
        if (state == la_pkg::EXECUTE) begin
            data_sram_addr  <= alu_result;
            data_sram_wdata <= rkd_value;
            result_q        <= alu_result;
        end
    end

    // Load data is valid from the SRAM during WRITEBACK
    assign rf_we    = (state == la_pkg::WRITEBACK) && ctrl.gr_we;
    assign rf_waddr = ctrl.dest;
    assign rf_wdata = ctrl.res_from_mem ? data_sram_rdata : result_q;

    assign debug_wb_pc       = inst_pc;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = rf_waddr;
    assign debug_wb_rf_wdata = rf_wdata;

endmodule

//--- rtl/la_core_top.sv
`timescale 1ns/10ps

module la_core_top #(
    parameter la_pkg::word_t RESET_PC = 32'h1c00_0000
) (
    input  logic             clk,
    input  logic             reset,
    output la_pkg::word_t    inst_sram_addr,
    input  la_pkg::word_t    inst_sram_rdata,
    output logic             data_sram_we,
    output la_pkg::word_t    data_sram_addr,
    output la_pkg::word_t    data_sram_wdata,
    input  la_pkg::word_t    data_sram_rdata,
    output la_pkg::word_t    debug_wb_pc,
    output logic [3:0]       debug_wb_rf_we,
    output la_pkg::reg_idx_t debug_wb_rf_wnum,
    output la_pkg::word_t    debug_wb_rf_wdata
);

    la_pkg::core_state_t state;
    la_pkg::word_t       pc;
    la_pkg::word_t       inst_pc;           // pc held for the instruction in flight
    la_pkg::inst_word_u  inst;
    logic                has_mem, is_load, is_branch_only;
    la_pkg::reg_idx_t    rf_raddr1, rf_raddr2, rf_waddr;
    la_pkg::word_t       rj_value, rkd_value, rf_wdata;
    logic                rf_we;
    la_pkg::word_t       alu_result, br_target;
    logic                br_taken;

    ctrl_if u_ctrl ();

    assign inst_sram_addr = pc;
    assign debug_wb_pc    = inst_pc;

    fetch_control #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk (clk), .reset (reset),
        .br_taken (br_taken), .br_target (br_target),
        .inst_sram_rdata (inst_sram_rdata),
        .state (state), .pc (pc), .inst (inst),
        .has_mem (has_mem), .is_load (is_load), .is_branch_only (is_branch_only)
    );

    inst_decoder u_decoder (
        .inst (inst), .ctrl (u_ctrl.decoder),
        .rf_raddr1 (rf_raddr1), .rf_raddr2 (rf_raddr2),
        .has_mem (has_mem), .is_load (is_load), .is_branch_only (is_branch_only)
    );

    regfile u_regfile (
        .clk (clk),
        .raddr1 (rf_raddr1), .rdata1 (rj_value),
        .raddr2 (rf_raddr2), .rdata2 (rkd_value),
        .we (rf_we), .waddr (rf_waddr), .wdata (rf_wdata)
    );

    exec_unit u_exec (
        .ctrl (u_ctrl.exec), .pc (inst_pc),
        .rj_value (rj_value), .rkd_value (rkd_value),
        .alu_result (alu_result), .br_taken (br_taken), .br_target (br_target)
    );

    result_unit u_result (
        .clk (clk), .reset (reset), .state (state), .ctrl (u_ctrl.result),
        .alu_result (alu_result), .rkd_value (rkd_value), .pc (pc),
        .data_sram_rdata (data_sram_rdata), .data_sram_we (data_sram_we),
        .data_sram_addr (data_sram_addr), .data_sram_wdata (data_sram_wdata),
        .rf_we (rf_we), .rf_waddr (rf_waddr), .rf_wdata (rf_wdata),
        .debug_wb_pc (inst_pc), .debug_wb_rf_we (debug_wb_rf_we),
        .debug_wb_rf_wnum (debug_wb_rf_wnum), .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

endmodule

//--- testbench/tb_la_core.sv
`timescale 1ns/10ps

module tb_la_core;

    localparam int            CLK_PERIOD  = 20;
    localparam int            NUM_TESTS   = 6;
    localparam int            IDLE_CYCLES = 20;
    localparam la_pkg::word_t RESET_PC    = 32'h1c00_0000;

    // LoongArch opcode fields
    localparam logic [16:0] OP_ADD   = 17'h00020;
    localparam logic [16:0] OP_SUB   = 17'h00022;
    localparam logic [16:0] OP_SLT   = 17'h00024;
    localparam logic [16:0] OP_SLTU  = 17'h00025;
    localparam logic [16:0] OP_NOR   = 17'h00028;
    localparam logic [16:0] OP_AND   = 17'h00029;
    localparam logic [16:0] OP_OR    = 17'h0002a;
    localparam logic [16:0] OP_XOR   = 17'h0002b;
    localparam logic [16:0] OP_SLLI  = 17'h00081;
    localparam logic [16:0] OP_SRLI  = 17'h00089;
    localparam logic [16:0] OP_SRAI  = 17'h00091;
    localparam logic [9:0]  OP_ADDI  = 10'h00a;
    localparam logic [9:0]  OP_LDW   = 10'h0a2;
    localparam logic [9:0]  OP_STW   = 10'h0a6;
    localparam logic [6:0]  OP_LU12I = 7'h0a;
    localparam logic [5:0]  OP_JIRL  = 6'h13;
    localparam logic [5:0]  OP_B     = 6'h14;
    localparam logic [5:0]  OP_BL    = 6'h15;
    localparam logic [5:0]  OP_BEQ   = 6'h16;
    localparam logic [5:0]  OP_BNE   = 6'h17;
    localparam logic [16:0] REG_OPS [8] = '{OP_ADD, OP_SUB, OP_SLT, OP_SLTU,
                                            OP_NOR, OP_AND, OP_OR, OP_XOR};

    logic             clk;
    logic             reset;
    la_pkg::word_t    inst_sram_addr;
    la_pkg::word_t    inst_sram_rdata = '0;
    logic             data_sram_we;
    la_pkg::word_t    data_sram_addr;
    la_pkg::word_t    data_sram_wdata;
    la_pkg::word_t    data_sram_rdata = '0;
    la_pkg::word_t    debug_wb_pc;
    logic [3:0]       debug_wb_rf_we;
    la_pkg::reg_idx_t debug_wb_rf_wnum;
    la_pkg::word_t    debug_wb_rf_wdata;

    la_pkg::word_t    inst_mem [256];
    la_pkg::word_t    data_mem [256];
    la_pkg::word_t    seed = 32'h9363_a9e6;
    int               error_count = 0;
    int               check_count = 0;

    la_pkg::word_t    prog_q[$];
    la_pkg::word_t    exp_pc[$], exp_data[$], exp_st_addr[$], exp_st_data[$];
    la_pkg::reg_idx_t exp_num[$];
    la_pkg::word_t    seen_pc[$], seen_data[$], seen_st_addr[$], seen_st_data[$];
    la_pkg::reg_idx_t seen_num[$];

    la_core_top #(
        .RESET_PC (RESET_PC)
    ) UUT (
        .clk (clk), .reset (reset),
        .inst_sram_addr (inst_sram_addr), .inst_sram_rdata (inst_sram_rdata),
        .data_sram_we (data_sram_we), .data_sram_addr (data_sram_addr),
        .data_sram_wdata (data_sram_wdata), .data_sram_rdata (data_sram_rdata),
        .debug_wb_pc (debug_wb_pc), .debug_wb_rf_we (debug_wb_rf_we),
        .debug_wb_rf_wnum (debug_wb_rf_wnum), .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // Synchronous-read SRAMs, data returns one edge after the address
    always @(posedge clk) begin
        inst_sram_rdata <= inst_mem[inst_sram_addr[9:2]];
    end

    always @(posedge clk) begin
        if (data_sram_we) begin
            data_mem[data_sram_addr[9:2]] <= data_sram_wdata;
        end
        data_sram_rdata <= data_mem[data_sram_addr[9:2]];
    end

    // Trace and store recorder, sampled mid-cycle
    always @(negedge clk) begin
        if (reset) begin
            seen_pc.delete();
            seen_num.delete();
            seen_data.delete();
            seen_st_addr.delete();
            seen_st_data.delete();
        end else begin
            if (debug_wb_rf_we == 4'hf) begin
                seen_pc.push_back(debug_wb_pc);
                seen_num.push_back(debug_wb_rf_wnum);
                seen_data.push_back(debug_wb_rf_wdata);
            end
            if (data_sram_we) begin
                seen_st_addr.push_back(data_sram_addr);
                seen_st_data.push_back(data_sram_wdata);
            end
        end
    end

    function automatic la_pkg::word_t lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic la_pkg::word_t three_reg_word(logic [16:0] op, la_pkg::reg_idx_t rk,
                                                     la_pkg::reg_idx_t rj, la_pkg::reg_idx_t rd);
        return {op, rk, rj, rd};
    endfunction

    function automatic la_pkg::word_t reg_imm12_word(logic [9:0] op, logic [11:0] si12,
                                                     la_pkg::reg_idx_t rj, la_pkg::reg_idx_t rd);
        return {op, si12, rj, rd};
    endfunction

    function automatic la_pkg::word_t branch16_word(logic [5:0] op, logic [15:0] offs16,
                                                    la_pkg::reg_idx_t rj, la_pkg::reg_idx_t rd);
        return {op, offs16, rj, rd};
    endfunction

    // High offset bits sit in the low ten instruction bits
    function automatic la_pkg::word_t branch26_word(logic [5:0] op, logic [25:0] offs26);
        return {op, offs26[15:0], offs26[25:16]};
    endfunction

    function automatic la_pkg::word_t cur_pc();
        return RESET_PC + la_pkg::word_t'(4 * prog_q.size());
    endfunction

    task automatic emit(la_pkg::word_t w);
        prog_q.push_back(w);
    endtask

    task automatic emit_write(la_pkg::word_t w, la_pkg::reg_idx_t rd, la_pkg::word_t value);
        exp_pc.push_back(cur_pc());
        exp_num.push_back(rd);
        exp_data.push_back(value);
        emit(w);
    endtask

    // lu12i then addi, upper part rounded for the signed low immediate
    task automatic set_reg(la_pkg::reg_idx_t rd, la_pkg::word_t value);
        la_pkg::word_t upper;
        la_pkg::word_t lo;
        upper = (value + 32'h800) & 32'hffff_f000;
        lo    = {{20{value[11]}}, value[11:0]};
        emit_write({OP_LU12I, upper[31:12], rd}, rd, upper);
        emit_write(reg_imm12_word(OP_ADDI, value[11:0], rd, rd), rd, upper + lo);
    endtask

    task automatic check_word(string name, la_pkg::word_t actual, la_pkg::word_t expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, actual, expected);
        end
    endtask

    task automatic check_reg(string name, la_pkg::reg_idx_t actual, la_pkg::reg_idx_t expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED %s: got 0x%02h, expected 0x%02h", name, actual, expected);
        end
    endtask

    task automatic run_program(string name);
        emit(branch26_word(OP_B, 26'd0));       // Park on a self loop
        @(posedge clk);
        reset <= 1'b1;
        @(negedge clk);
        for (int i = 0; i < 256; i++) begin
            inst_mem[i] = (i < prog_q.size()) ? prog_q[i] : 32'd0;
        end
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        while (seen_pc.size() < exp_pc.size() || seen_st_addr.size() < exp_st_addr.size()) begin
            @(posedge clk);
        end
        repeat (IDLE_CYCLES) @(posedge clk);
        if (seen_pc.size() != exp_pc.size()) begin
            error_count++;
            $display("%s: %0d register writes on the trace, expected %0d",
                     name, seen_pc.size(), exp_pc.size());
        end
        if (seen_st_addr.size() != exp_st_addr.size()) begin
            error_count++;
            $display("%s: %0d stores seen, expected %0d",
                     name, seen_st_addr.size(), exp_st_addr.size());
        end
        foreach (exp_pc[i]) begin
            check_word($sformatf("%s debug_wb_pc #%0d", name, i), seen_pc[i], exp_pc[i]);
            check_reg($sformatf("%s debug_wb_rf_wnum #%0d", name, i), seen_num[i], exp_num[i]);
            check_word($sformatf("%s debug_wb_rf_wdata #%0d", name, i), seen_data[i], exp_data[i]);
        end
        foreach (exp_st_addr[i]) begin
            check_word($sformatf("%s data_sram_addr #%0d", name, i),
                       seen_st_addr[i], exp_st_addr[i]);
            check_word($sformatf("%s data_sram_wdata #%0d", name, i),
                       seen_st_data[i], exp_st_data[i]);
        end
        prog_q.delete();
        exp_pc.delete();
        exp_num.delete();
        exp_data.delete();
        exp_st_addr.delete();
        exp_st_data.delete();
    endtask

    task automatic run_reg_ops();
        la_pkg::word_t a;
        la_pkg::word_t b;
        la_pkg::word_t want;
        a = lcg_next() | 32'h8000_0000;         // Negative against positive splits slt and sltu
        b = lcg_next() & 32'h7fff_ffff;
        set_reg(5'd4, a);
        set_reg(5'd5, b);
        for (int i = 0; i < 8; i++) begin
            case (i)
                0: want = a + b;
                1: want = a - b;
                2: want = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3: want = (a < b) ? 32'd1 : 32'd0;
                4: want = ~(a | b);
                5: want = a & b;
                6: want = a | b;
                default: want = a ^ b;
            endcase
            emit_write(three_reg_word(REG_OPS[i], 5'd5, 5'd4, la_pkg::reg_idx_t'(6 + i)),
                       la_pkg::reg_idx_t'(6 + i), want);
        end
        run_program("reg_ops");
    endtask

    task automatic run_imm_ops();
        la_pkg::word_t a;
        la_pkg::word_t r;
        logic [11:0]   imm;
        a   = lcg_next() | 32'h8000_0000;
        r   = lcg_next();
        imm = {1'b1, r[26:16]};
        set_reg(5'd4, a);
        emit_write(three_reg_word(OP_SLLI, r[4:0], 5'd4, 5'd10), 5'd10, a << r[4:0]);
        emit_write(three_reg_word(OP_SRLI, r[9:5], 5'd4, 5'd11), 5'd11, a >> r[9:5]);
        emit_write(three_reg_word(OP_SRAI, r[14:10], 5'd4, 5'd12), 5'd12,
                   $signed(a) >>> r[14:10]);
        emit_write(reg_imm12_word(OP_ADDI, imm, 5'd4, 5'd13), 5'd13, a + {{20{imm[11]}}, imm});
        run_program("imm_ops");
    endtask

    task automatic run_store_load();
        la_pkg::word_t base;
        la_pkg::word_t data;
        la_pkg::word_t r;
        logic [11:0]   off;
        base = 32'h1c00_8000 | (lcg_next() & 32'h0000_03fc);
        data = lcg_next();
        r    = lcg_next();
        off  = {r[31:22], 2'b00};
        set_reg(5'd4, base);
        set_reg(5'd5, data);
        exp_st_addr.push_back(base + {{20{off[11]}}, off});
        exp_st_data.push_back(data);
        emit(reg_imm12_word(OP_STW, off, 5'd4, 5'd5));
        emit_write(reg_imm12_word(OP_LDW, off, 5'd4, 5'd6), 5'd6, data);
        run_program("store_load");
    endtask

    task automatic run_cond_branches();
        la_pkg::word_t    v;
        la_pkg::word_t    other;
        la_pkg::reg_idx_t rd_sel;
        logic [5:0]       op;
        logic             taken;
        v = lcg_next();
        set_reg(5'd4, v);
        set_reg(5'd5, v);
        set_reg(5'd6, v ^ 32'h0000_0100);
        for (int i = 0; i < 4; i++) begin
            op     = (i < 2) ? OP_BEQ : OP_BNE;
            rd_sel = (i == 0 || i == 3) ? 5'd5 : 5'd6;
            other  = (rd_sel == 5'd5) ? v : v ^ 32'h0000_0100;
            taken  = (op == OP_BEQ) == (v == other);
            emit(branch16_word(op, 16'd2, 5'd4, rd_sel));
            if (taken) begin
                emit(reg_imm12_word(OP_ADDI, 12'h7ff, 5'd0, 5'd7));
            end else begin
                emit_write(reg_imm12_word(OP_ADDI, 12'h7ff, 5'd0, 5'd7), 5'd7, 32'h0000_07ff);
            end
            emit_write(reg_imm12_word(OP_ADDI, 12'(i), 5'd0, 5'd8), 5'd8, 32'(i));
        end
        run_program("cond_branches");
    endtask

    task automatic run_jumps();
        la_pkg::word_t jpc;
        jpc = cur_pc();
        emit_write(branch26_word(OP_BL, 26'd3), 5'd1, jpc + 32'd4);
        emit(reg_imm12_word(OP_ADDI, 12'd1, 5'd0, 5'd7));
        emit(reg_imm12_word(OP_ADDI, 12'd2, 5'd0, 5'd7));
        emit_write(reg_imm12_word(OP_ADDI, 12'd3, 5'd0, 5'd8), 5'd8, 32'd3);
        // Base 16 bytes below the jirl so a pc-relative target would miss
        jpc = cur_pc() + 32'd8;
        set_reg(5'd9, jpc - 32'd16);
        emit_write(branch16_word(OP_JIRL, 16'd6, 5'd9, 5'd10), 5'd10, jpc + 32'd4);
        emit(reg_imm12_word(OP_ADDI, 12'd4, 5'd0, 5'd7));
        emit_write(reg_imm12_word(OP_ADDI, 12'd5, 5'd0, 5'd11), 5'd11, 32'd5);
        emit(branch26_word(OP_B, 26'd2));
        emit(reg_imm12_word(OP_ADDI, 12'd6, 5'd0, 5'd7));
        emit_write(reg_imm12_word(OP_ADDI, 12'd7, 5'd0, 5'd12), 5'd12, 32'd7);
        run_program("jumps");
    endtask

    task automatic run_zero_reg();
        la_pkg::word_t a;
        a = lcg_next();
        set_reg(5'd4, a);
        emit_write(reg_imm12_word(OP_ADDI, 12'd5, 5'd4, 5'd0), 5'd0, a + 32'd5);
        emit_write(three_reg_word(OP_ADD, 5'd4, 5'd0, 5'd5), 5'd5, a);
        emit_write(three_reg_word(OP_ADD, 5'd0, 5'd4, 5'd6), 5'd6, a);
        run_program("zero_reg");
    endtask

    initial begin
        reset = 1'b1;
        run_reg_ops();
        run_imm_ops();
        run_store_load();
        run_cond_branches();
        run_jumps();
        run_zero_reg();
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #(NUM_TESTS * 400 * CLK_PERIOD);
        $display("Timeout: tests still running after %0d clock cycles", NUM_TESTS * 400);
        $display("TEST FAIL");
        $finish;
    end

endmodule

//--- sim.f
common/la_pkg.sv
common/ctrl_if.sv
execute/alu.sv
execute/exec_unit.sv
decode/inst_decoder.sv
rtl/regfile.sv
rtl/fetch_control.sv
rtl/result_unit.sv
rtl/la_core_top.sv
testbench/tb_la_core.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the core testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/10ps \
    -f sim.f --top-module tb_la_core -o tb_la_core

./obj_dir/tb_la_core > sim.log 2>&1 || true
cat sim.log

if grep -qx "TEST PASS" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
